/* Add.sv */
`timescale 1ns/100ps

module PrefixAndOr #(
	parameter int width = 8,  // word width
	parameter int speed = 0   // 0 serial, 1 Brent-Kung, 2 Sklansky
) (
	input  logic [width-1:0] GI,  // generate in
	input  logic [width-1:0] PI,  // propagate in
	output logic [width-1:0] GO,  // prefix generate out
	output logic [width-1:0] PO   // prefix propagate out
);

	localparam int m = $clog2(width);  // levels of a log-depth tree

	if (speed == 2) begin : fastPrefix
		logic [m:0][width-1:0] gT, pT;  // one row per level
		assign gT[0] = GI;
		assign pT[0] = PI;
		for (genvar l = 1; l <= m; l++) begin : levels
			for (genvar j = 0; j < width; j++) begin : bits
				// last bit of the lower half of this bit's block
				localparam int src = (j / 2**l) * 2**l + 2**(l-1) - 1;
				if ((j / 2**(l-1)) % 2 == 1) begin : black
					assign gT[l][j] = gT[l-1][j] | (pT[l-1][j] & gT[l-1][src]);
					assign pT[l][j] = pT[l-1][j] & pT[l-1][src];
				end else begin : white  // lower half just passes through
					assign gT[l][j] = gT[l-1][j];
					assign pT[l][j] = pT[l-1][j];
				end
			end
		end
		assign GO = gT[m];
		assign PO = pT[m];
	end else if (speed == 1) begin : mediumPrefix
		// m levels up the tree, m-1 levels back down
		logic [2*m-1:0][width-1:0] gT, pT;
		assign gT[0] = GI;
		assign pT[0] = PI;
		for (genvar l = 1; l < 2*m; l++) begin : levels
			localparam bit up = (l <= m);
			localparam int d = up ? l : 2*m - l;  // span exponent of this level
			for (genvar j = 0; j < width; j++) begin : bits
				localparam bit upNode = up && ((j+1) % 2**d == 0);
				localparam bit downNode = !up && ((j+1) % 2**d == 2**(d-1)) && (j+1 > 2**d);
				if (upNode || downNode) begin : black
					assign gT[l][j] = gT[l-1][j] | (pT[l-1][j] & gT[l-1][j - 2**(d-1)]);
					assign pT[l][j] = pT[l-1][j] & pT[l-1][j - 2**(d-1)];
				end else begin : white
					assign gT[l][j] = gT[l-1][j];
					assign pT[l][j] = pT[l-1][j];
				end
			end
		end
		assign GO = gT[2*m-1];
		assign PO = pT[2*m-1];
	end else begin : slowPrefix
		logic [width-1:0] gT, pT;  // serial chain, one node per bit
		assign gT[0] = GI[0];
		assign pT[0] = PI[0];
		for (genvar i = 1; i < width; i++) begin : bits
			assign gT[i] = GI[i] | (PI[i] & gT[i-1]);
			assign pT[i] = PI[i] & pT[i-1];
		end
		assign GO = gT;
		assign PO = pT;
	end

endmodule

module Add #(
	parameter int width = 8,  // word width
	parameter int speed = 0   // 0 ripple, else prefix structure
) (
	input  logic [width-1:0] A,
	input  logic [width-1:0] B,
	output logic [width-1:0] S   // sum modulo 2**width
);

	if (speed == 0) begin : slowAdd
		assign S = A + B;  // tool picks the ripple form
	end else begin : prefixAdd
		logic [width-1:0] gI, pI;  // bitwise generate / propagate
		logic [width-1:0] gO;      // carry out of each bit position
		logic [width-1:0] hS;      // half sum

		assign gI = A & B;
		assign pI = A | B;  // or-propagate is enough for carries
		assign hS = A ^ B;

		PrefixAndOr #(
			.width(width),
			.speed(speed)
		) prefix (
			.GI(gI),
			.PI(pI),
			.GO(gO),
			.PO()  // group propagate not needed without carry-in
		);

		// carry into bit i is the prefix generate of bit i-1
		assign S = hS ^ {gO[width-2:0], 1'b0};
	end

endmodule

/* AddMopCsv.sv */
`timescale 1ns/100ps

module Cpr #(
	parameter int depth = 4,  // input bits of this weight
	parameter int speed = 0   // 0 linear chain, else tree
) (
	input  logic [depth-1:0] A,   // operand bits, same weight
	input  logic [depth-4:0] CI,  // carries from the slice below
	output logic             S,   // sum bit
	output logic             C,   // carry to next weight
	output logic [depth-4:0] CO   // carries to the slice above
);

	logic [depth-3:0] cT;  // carry of every full-adder cell

	function automatic logic maj(input logic a, input logic b, input logic c);
		return (a & b) | (a & c) | (b & c);
	endfunction

	if (speed == 0) begin : slowCpr
		logic [depth-3:0] sT;  // running sum down the chain

		// first cell takes three operand bits
		assign sT[0] = A[0] ^ A[1] ^ A[2];
		assign cT[0] = maj(A[0], A[1], A[2]);
		for (genvar i = 1; i < depth-2; i++) begin : linear
			// one new operand, one incoming carry, previous sum
			assign sT[i] = A[i+2] ^ CI[i-1] ^ sT[i-1];
			assign cT[i] = maj(A[i+2], CI[i-1], sT[i-1]);
		end
		assign S = sT[depth-3];
	end else begin : fastCpr
		// queue of bits still to be added, cells eat three at a time
		logic [3*depth-6:0] F;

		assign F[depth-1:0] = A;
		for (genvar i = 0; i < depth-2; i++) begin : tree
			assign F[depth+2*i] = F[3*i] ^ F[3*i+1] ^ F[3*i+2];  // sum back on the queue
			assign cT[i] = maj(F[3*i], F[3*i+1], F[3*i+2]);
			if (i < depth-3) begin : feed
				assign F[depth+2*i+1] = CI[i];  // carry from below joins queue
			end
		end
		assign S = F[3*depth-6];  // last cell's sum
	end

	assign CO = cT[depth-4:0];
	assign C  = cT[depth-3];  // last cell goes out as the carry vector bit

endmodule

module AddMopCsv #(
	parameter int width = 8,  // word width
	parameter int depth = 4,  // operand count
	parameter int speed = 0   // compressor structure
) (
	input  logic [depth*width-1:0] A,  // operand k at bits k*width
	output logic [width-1:0]       S,  // sum vector
	output logic [width-1:0]       C   // carry vector, weight already shifted
);

	logic [depth*width-1:0]         aT;     // bits grouped by weight
	logic [(depth-3)*(width+1)-1:0] chain;  // carries between slices
	logic [width-1:0]               cT;     // carry per slice, unshifted

	always_comb begin : regroup
		for (int k = 0; k < depth; k++) begin
			for (int i = 0; i < width; i++) begin
				aT[i*depth+k] = A[k*width+i];
			end
		end
	end

	assign chain[depth-4:0] = '0;  // lsb slice sees no carries

	for (genvar i = 0; i < width; i++) begin : bits
		Cpr #(
			.depth(depth),
			.speed(speed)
		) slice (
			.A (aT[i*depth +: depth]),
			.CI(chain[i*(depth-3) +: depth-3]),
			.S (S[i]),
			.C (cT[i]),
			.CO(chain[(i+1)*(depth-3) +: depth-3])  // top chunk falls off, mod 2**width
		);
	end

	assign C = {cT[width-2:0], 1'b0};

endmodule

/* MopCompressStage.sv */
`timescale 1ns/100ps

module MopCompressStage (
	input  logic                                              clk,
	input  logic                                              arstN,
	input  logic                                              inValid,
	input  logic                                              inSigned,  // sign-extend when set
	input  logic [mopFormatPkg::tagWidth-1:0]                 inTag,
	input  logic [mopFormatPkg::opCount*mopFormatPkg::opWidth-1:0] inOperands,
	mopStageIf.producer                                       stage
);
	import mopFormatPkg::*;
	import mopArithPkg::*;

	logic [opCount*sumWidth-1:0] extOps;    // operands at full sum width
	logic [sumWidth-1:0]         sumC;      // compressor outputs
	logic [sumWidth-1:0]         carryC;

	for (genvar k = 0; k < opCount; k++) begin : extend
		logic [opWidth-1:0] op;
		logic               fill;  // value of the new top bits
		assign op   = inOperands[k*opWidth +: opWidth];
		assign fill = inSigned & op[opMsb];
		assign extOps[k*sumWidth +: sumWidth] = {{extBits{fill}}, op};
	end

	AddMopCsv #(
		.width(sumWidth),
		.depth(opCount),
		.speed(compressSpeed)
	) compress (
		.A(extOps),
		.S(sumC),
		.C(carryC)
	);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) stage.valid <= 1'b0;
		else        stage.valid <= inValid;
	end

	// payload only moves with a valid item
	always_ff @(posedge clk) begin
		if (inValid) begin
			stage.tag      <= inTag;
			stage.sumVec   <= sumC;
			stage.carryVec <= carryC;
		end
	end

endmodule

/* MopFinalStage.sv */
`timescale 1ns/100ps

module MopFinalStage (
	input  logic                              clk,
	input  logic                              arstN,
	mopStageIf.consumer                       stage,
	output logic                              outValid,
	output logic [mopFormatPkg::tagWidth-1:0] outTag,
	output logic [mopFormatPkg::sumWidth-1:0] outSum
);
	import mopFormatPkg::*;
	import mopArithPkg::*;

	logic [sumWidth-1:0] sum;  // carry-propagate result, combinational

	Add #(
		.width(sumWidth),
		.speed(adderSpeed)
	) finalAdd (
		.A(stage.sumVec),
		.B(stage.carryVec),
		.S(sum)
	);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) outValid <= 1'b0;
		else        outValid <= stage.valid;
	end

	always_ff @(posedge clk) begin
		if (stage.valid) begin  // hold last result when idle
			outSum <= sum;
			outTag <= stage.tag;
		end
	end

endmodule

/* MopSumUnit.sv */
`timescale 1ns/100ps

module MopSumUnit (
	input  logic                                                   clk,
	input  logic                                                   arstN,
	input  logic                                                   inValid,
	input  logic                                                   inSigned,
	input  logic [mopFormatPkg::tagWidth-1:0]                      inTag,
	input  logic [mopFormatPkg::opCount*mopFormatPkg::opWidth-1:0] inOperands,
	output logic                                                   outValid,
	output logic [mopFormatPkg::tagWidth-1:0]                      outTag,
	output logic [mopFormatPkg::sumWidth-1:0]                      outSum
);

	// carry-save item between the two pipeline registers
	mopStageIf stageIf ();

	// stage 1, extend and compress, register at edge n
	MopCompressStage compressStage (
		.clk       (clk),
		.arstN     (arstN),
		.inValid   (inValid),
		.inSigned  (inSigned),
		.inTag     (inTag),
		.inOperands(inOperands),
		.stage     (stageIf.producer)
	);

	// stage 2, prefix add, register at edge n+1
	MopFinalStage finalStage (
		.clk     (clk),
		.arstN   (arstN),
		.stage   (stageIf.consumer),
		.outValid(outValid),
		.outTag  (outTag),
		.outSum  (outSum)
	);

endmodule

/* all.f */
mopFormatPkg.sv
mopArithPkg.sv
mopStageIf.sv
Add.sv
AddMopCsv.sv
MopCompressStage.sv
MopFinalStage.sv
MopSumUnit.sv
tbMopSumUnit_chk.sv
tbMopMonitor.sv
tbMopSumUnit.sv

/* mopArithPkg.sv */
package mopArithPkg;

	// compressor array
	// 1 = full-adder tree per slice, 0 = linear chain
	localparam int compressSpeed = 1;

	// final carry-propagate adder
	// 2 = Sklansky, 1 = Brent-Kung, 0 = ripple
	localparam int adderSpeed = 2;

endpackage

/* mopFormatPkg.sv */
package mopFormatPkg;

	// item format seen at the unit boundary
	localparam int opWidth = 8;  // bits per operand
	localparam int opCount = 6;  // operands per item, compressor needs 4 or more

	// three guard bits cover six operands in either signedness
	localparam int sumWidth = opWidth + 3;

	localparam int tagWidth = 4;  // item tag, travels with the sum

	// sign bit of an operand
	localparam int opMsb = opWidth - 1;

	// extension bits added in front of each operand
	localparam int extBits = sumWidth - opWidth;

endpackage

/* mopStageIf.sv */
`timescale 1ns/100ps

interface mopStageIf;
	import mopFormatPkg::*;

	logic                valid;     // one strobe per item
	logic [tagWidth-1:0] tag;
	logic [sumWidth-1:0] sumVec;    // carry-save sum part
	logic [sumWidth-1:0] carryVec;  // carry-save carry part, already shifted

	// compress side
	modport producer (
		output valid, tag, sumVec, carryVec
	);

	// final adder side
	modport consumer (
		input valid, tag, sumVec, carryVec
	);

endinterface

/* run.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator, pass or fail from the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tbMopSumUnit -o simTb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

# keep running past assertion errors so the closing report is printed
./obj_dir/simTb +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Test OK" "$LOG"; then
	exit 0
fi
exit 1

/* tbMopMonitor.sv */
`timescale 1ns/100ps

module tbMopMonitor (
	input  logic                                                   clk,
	input  logic                                                   arstN,
	input  logic                                                   inValid,
	input  logic                                                   inSigned,
	input  logic [mopFormatPkg::tagWidth-1:0]                      inTag,
	input  logic [mopFormatPkg::opCount*mopFormatPkg::opWidth-1:0] inOperands,
	input  logic                                                   outValid,
	input  logic [mopFormatPkg::tagWidth-1:0]                      outTag,
	input  logic [mopFormatPkg::sumWidth-1:0]                      outSum,
	input  logic [95:0]                                            testName,  // packed text
	input  logic                                                   endOfTest,
	output int                                                     valueErrors,
	output int                                                     otherErrors,
	output int                                                     pending
);
	import mopFormatPkg::*;

	logic [sumWidth-1:0] expQ[$];  // expected sums, oldest first
	logic [tagWidth-1:0] tagQ[$];
	logic [95:0]         nameQ[$];
	logic [sumWidth-1:0] expS;
	logic [tagWidth-1:0] expT;
	logic [95:0]         expN;
	int                  valErr = 0;
	int                  othErr = 0;
	int                  pendCnt = 0;

	assign valueErrors = valErr;
	assign otherErrors = othErr;
	assign pending     = pendCnt;

	// exact sum of the extended operands, wrapped to the sum width
	function automatic logic [sumWidth-1:0] refSum(input logic [opCount*opWidth-1:0] ops,
		input logic sgn);
		int acc;
		acc = 0;
		for (int k = 0; k < opCount; k++) begin
			if (sgn) acc += int'($signed(ops[k*opWidth +: opWidth]));
			else     acc += int'(ops[k*opWidth +: opWidth]);
		end
		return acc[sumWidth-1:0];
	endfunction

	always @(posedge clk) begin
		if (!arstN) begin
			if (outValid) begin
				$display("ERROR: outValid high while reset is held");
				othErr++;
			end
		end else begin
			if (outValid) begin
				if (expQ.size() == 0) begin
					$display("ERROR: output with tag %0d appeared with no item outstanding", outTag);
					othErr++;
				end else begin
					expS = expQ.pop_front();
					expT = tagQ.pop_front();
					expN = nameQ.pop_front();
					if (outSum !== expS) begin
						$display("CHECK FAILED %s: sum expected %0d, actual %0d", expN, expS, outSum);
						valErr++;
					end
					if (outTag !== expT) begin
						$display("CHECK FAILED %s: tag expected %0d, actual %0d", expN, expT, outTag);
						valErr++;
					end
				end
			end
			if (inValid) begin  // accepted item
				expQ.push_back(refSum(inOperands, inSigned));
				tagQ.push_back(inTag);
				nameQ.push_back(testName);
			end
		end
		pendCnt = expQ.size();
	end

	always @(posedge endOfTest) begin
		if (expQ.size() != 0) begin
			$display("ERROR: %0d items never came out of the unit", expQ.size());
			othErr++;
		end
	end

endmodule

/* tbMopSumUnit.sv */
`timescale 1ns/100ps

module tbMopSumUnit;
	import mopFormatPkg::*;

	logic                       clk;
	logic                       arstN;
	logic                       inValid;
	logic                       inSigned;
	logic [tagWidth-1:0]        inTag;
	logic [opCount*opWidth-1:0] inOperands;
	logic                       outValid;
	logic [tagWidth-1:0]        outTag;
	logic [sumWidth-1:0]        outSum;
	logic [95:0]                testName;   // name of the item on the inputs
	logic                       endOfTest;
	int                         valueErrors;
	int                         otherErrors;
	int                         pending;
	int                         timeouts = 0;
	int                         totalErrors;

	// stimulus table, one row per item
	string                      nameQ[$];
	logic [opCount*opWidth-1:0] opsQ[$];
	logic                       sgnQ[$];
	int                         idleQ[$];  // idle cycles after the item

	logic [31:0]                lcgState = 32'h800c01e8;
	logic [31:0]                r0;
	logic [31:0]                r1;
	logic [tagWidth-1:0]        tagCnt = '0;

	MopSumUnit MopSumUnit_i (
		.clk       (clk),
		.arstN     (arstN),
		.inValid   (inValid),
		.inSigned  (inSigned),
		.inTag     (inTag),
		.inOperands(inOperands),
		.outValid  (outValid),
		.outTag    (outTag),
		.outSum    (outSum)
	);

	tbMopMonitor monitor (.*);

	function automatic logic [31:0] nextRand(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [95:0] toPacked(input string s);
		logic [95:0] r;
		r = '0;
		for (int i = 0; i < s.len() && i < 12; i++) r = {r[87:0], s[i]};
		return r;
	endfunction

	task automatic addEntry(input string nm, input logic [opCount*opWidth-1:0] ops,
		input logic sgn, input int idle);
		nameQ.push_back(nm);
		opsQ.push_back(ops);
		sgnQ.push_back(sgn);
		idleQ.push_back(idle);
	endtask

	task automatic buildTable();
		addEntry("unsMax", {6{8'hFF}}, 1'b0, 1);  // 1530
		addEntry("unsZero", {6{8'h00}}, 1'b0, 1);
		addEntry("sgnMin", {6{8'h80}}, 1'b1, 1);  // -768
		addEntry("sgnMix", {8'h9C, 8'h64, 8'hFB, 8'h05, 8'h80, 8'h7F}, 1'b1, 2);
		addEntry("flagLow", {8'h3C, 8'hC3, 8'h7E, 8'h81, 8'h0F, 8'hF0}, 1'b0, 0);
		addEntry("flagHigh", {8'h3C, 8'hC3, 8'h7E, 8'h81, 8'h0F, 8'hF0}, 1'b1, 3);
		addEntry("b2b0", {8'h01, 8'h02, 8'h03, 8'h04, 8'h05, 8'h06}, 1'b0, 0);
		addEntry("b2b1", {8'hFF, 8'h01, 8'hFF, 8'h01, 8'hFF, 8'h01}, 1'b1, 0);
		addEntry("b2b2", {8'h80, 8'h7F, 8'h80, 8'h7F, 8'h80, 8'h7F}, 1'b0, 0);
		addEntry("b2b3", {8'h11, 8'h22, 8'h33, 8'h44, 8'h55, 8'h66}, 1'b1, 4);
		for (int n = 0; n < 20; n++) begin
			lcgState = nextRand(lcgState);
			r0 = lcgState;
			lcgState = nextRand(lcgState);
			r1 = lcgState;
			addEntry($sformatf("rand%0d", n), {r0, r1[31:16]}, r1[15], int'(r1[14:13]) % 3);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		int waitCycles;
		arstN      = 1'b0;
		inValid    = 1'b0;
		inSigned   = 1'b0;
		inTag      = '0;
		inOperands = '0;
		testName   = '0;
		endOfTest  = 1'b0;
		buildTable();
		repeat (2) @(posedge clk);
		#10;
		arstN = 1'b1;

		for (int i = 0; i < nameQ.size(); i++) begin
			@(posedge clk);
			#10;  // drive clear of the edge
			inValid    = 1'b1;
			inSigned   = sgnQ[i];
			inOperands = opsQ[i];
			inTag      = tagCnt;
			testName   = toPacked(nameQ[i]);
			tagCnt     = tagCnt + 1'b1;  // wraps mod 16
			for (int j = 0; j < idleQ[i]; j++) begin
				@(posedge clk);
				#10;
				inValid = 1'b0;
			end
		end
		@(posedge clk);
		#10;
		inValid = 1'b0;

		// drain what is still in flight
		waitCycles = 0;
		while (pending != 0 && waitCycles < 20) begin
			@(posedge clk);
			#10;
			waitCycles++;
		end
		if (pending != 0) begin
			$display("ERROR: timed out waiting for %0d outstanding items", pending);
			timeouts++;
		end
		endOfTest = 1'b1;
		#10;

		totalErrors = valueErrors + otherErrors + timeouts + MopSumUnit_i.timingChk.assertFails;
		$display("errors: value %0d, other %0d, timeout %0d, assertion %0d", valueErrors,
			otherErrors, timeouts, MopSumUnit_i.timingChk.assertFails);
		if (totalErrors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* tbMopSumUnit_chk.sv */
`timescale 1ns/100ps

module tbMopSumUnit_chk (
	input logic                              clk,
	input logic                              arstN,
	input logic                              inValid,
	input logic                              outValid,
	input logic [mopFormatPkg::tagWidth-1:0] outTag,
	input logic [mopFormatPkg::sumWidth-1:0] outSum
);

	int assertFails = 0;  // read by the testbench at the end

	// item sampled at edge n is seen on the outputs at edge n+2
	latency: assert property (@(posedge clk) disable iff (!arstN) inValid |-> ##2 outValid)
		else begin
			$error("outValid missing two cycles after inValid");
			assertFails++;
		end

	noSpurious: assert property (@(posedge clk) disable iff (!arstN)
		outValid |-> $past(inValid, 2))
		else begin
			$error("outValid without an input two cycles earlier");
			assertFails++;
		end

	knownData: assert property (@(posedge clk) disable iff (!arstN)
		outValid |-> !$isunknown({outSum, outTag}))
		else begin
			$error("unknown bits on outSum or outTag");
			assertFails++;
		end

	quietReset: assert property (@(posedge clk) !arstN |-> !outValid)
		else begin
			$error("outValid high during reset");
			assertFails++;
		end

endmodule

bind MopSumUnit tbMopSumUnit_chk timingChk (
	.clk     (clk),
	.arstN   (arstN),
	.inValid (inValid),
	.outValid(outValid),
	.outTag  (outTag),
	.outSum  (outSum)
);
